// File: sched_pkg.sv
// Default array sizes, job configuration, register map, Wishbone and
// buffer-control types shared by the tile scheduler
`default_nettype none

package sched_pkg;

  // Default geometry of the processing array
  localparam int unsigned ArrayHeight = 8;
  localparam int unsigned ArrayWidth  = 8;
  localparam int unsigned TotDepth    = 8;
  localparam int unsigned PipeRegs    = 3;

  typedef struct packed {
    logic [15:0] x_cols_iters;
    logic [15:0] x_rows_iters;
    logic [15:0] w_cols_iters;
    logic [15:0] w_rows_iters;
    logic [7:0]  x_height_lo;
    logic [7:0]  x_width_lo;
    logic [7:0]  w_height_lo;
    logic [7:0]  w_width_lo;
  } sched_cfg_t;

  // Word addresses of the configuration registers
  typedef enum logic [3:0] {
    REG_X_ITERS   = 4'd0,
    REG_W_ITERS   = 4'd1,
    REG_LEFTOVERS = 4'd2,
    REG_CTRL      = 4'd3
  } sched_reg_e;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic       load;
    logic       h_shift;
    logic       pad_setup;
    logic       rst_w_index;
    logic [7:0] height;
    logic [7:0] width;
    logic [7:0] slots;
  } x_buf_ctrl_t;

  typedef struct packed {
    logic       load;
    logic       shift;
    logic [7:0] height;
    logic [7:0] width;
  } w_buf_ctrl_t;

endpackage

`default_nettype wire

// File: sched_cfg_regs.sv
// Wishbone classic slave with the job configuration and the start and
// clear control strobes
`default_nettype none

module sched_cfg_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  sched_pkg::wb_req_t    wb_req_i,
  output sched_pkg::wb_rsp_t    wb_rsp_o,
  output sched_pkg::sched_cfg_t cfg_o,
  output logic                  start_o,
  output logic                  clear_o
);

  sched_pkg::sched_cfg_t cfg_q;
  sched_pkg::sched_reg_e reg_addr;
  logic                  req;
  logic                  ctrl_wr;
  logic                  ack_q;
  logic [1:0]            ctrl_q;
  logic                  start_q;
  logic                  clear_q;
  logic [31:0]           rdata;
  logic [31:0]           rdata_q;

  assign reg_addr = sched_pkg::sched_reg_e'(wb_req_i.adr);

  // No new access is taken in the ack cycle, so every access acks once
  assign req     = wb_req_i.cyc && wb_req_i.stb && !ack_q;
  assign ctrl_wr = req && wb_req_i.we && (reg_addr == sched_pkg::REG_CTRL);

  always_comb begin
    rdata = '0;
    case (reg_addr)
      sched_pkg::REG_X_ITERS: begin
        rdata = {cfg_q.x_rows_iters, cfg_q.x_cols_iters};
      end
      sched_pkg::REG_W_ITERS: begin
        rdata = {cfg_q.w_rows_iters, cfg_q.w_cols_iters};
      end
      sched_pkg::REG_LEFTOVERS: begin
        rdata = {cfg_q.x_width_lo, cfg_q.x_height_lo, cfg_q.w_height_lo, cfg_q.w_width_lo};
      end
      // The control register is write-only and reads as zero
      default: begin
        rdata = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (req && wb_req_i.we) begin
      case (reg_addr)
        sched_pkg::REG_X_ITERS: begin
          cfg_q.x_rows_iters <= wb_req_i.dat[31:16];
          cfg_q.x_cols_iters <= wb_req_i.dat[15:0];
        end
        sched_pkg::REG_W_ITERS: begin
          cfg_q.w_rows_iters <= wb_req_i.dat[31:16];
          cfg_q.w_cols_iters <= wb_req_i.dat[15:0];
        end
        sched_pkg::REG_LEFTOVERS: begin
          cfg_q.x_width_lo  <= wb_req_i.dat[31:24];
          cfg_q.x_height_lo <= wb_req_i.dat[23:16];
          cfg_q.w_height_lo <= wb_req_i.dat[15:8];
          cfg_q.w_width_lo  <= wb_req_i.dat[7:0];
        end
        default: begin
        end
      endcase
    end
  end

  // Control bits pass one stage behind the ack, so start fires after it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      ctrl_q  <= 2'b00;
      start_q <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      ack_q   <= req;
      ctrl_q  <= ctrl_wr ? wb_req_i.dat[1:0] : 2'b00;
      start_q <= ctrl_q[0];
      clear_q <= ctrl_q[1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      rdata_q <= rdata;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;
  assign cfg_o        = cfg_q;
  assign start_o      = start_q;
  assign clear_o      = clear_q;

endmodule

`default_nettype wire

// File: x_tile_iter.sv
// X tile iteration counters, shift counter, reload and refill flags
// and X buffer control
`default_nettype none

module x_tile_iter #(
  parameter int unsigned Height   = sched_pkg::ArrayHeight,
  parameter int unsigned TotDepth = sched_pkg::TotDepth,
  parameter int unsigned Width    = sched_pkg::ArrayWidth
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  sched_pkg::sched_cfg_t  cfg_i,
  input  logic                   start_i,
  input  logic                   clear_i,
  input  logic                   x_full_i,
  input  logic                   x_empty_i,
  input  logic                   w_step_i,
  input  logic                   preload_done_i,
  output sched_pkg::x_buf_ctrl_t x_ctrl_o,
  output logic                   x_need_full_o,
  output logic                   x_done_o
);

  localparam int unsigned ShiftW = (Height > 1) ? $clog2(Height) : 1;

  logic [15:0]       cols_q;
  logic [15:0]       w_iters_q;
  logic [15:0]       rows_q;
  logic [ShiftW-1:0] shift_q;
  logic              x_done_q;
  logic              reload_q;
  logic              refill_q;
  logic              restart;
  logic              cols_last;
  logic              w_iters_last;
  logic              rows_last;
  logic              shift_last;
  logic              reload_en;
  logic              reload_rst;
  logic              rst_w_index;
  logic [7:0]        x_height;

  // A new job begins the iteration from zero, just like clear
  assign restart = clear_i || start_i;

  assign cols_last    = cols_q == cfg_i.x_cols_iters - 16'd1;
  assign w_iters_last = w_iters_q == cfg_i.w_cols_iters - 16'd1;
  assign rows_last    = rows_q == cfg_i.x_rows_iters - 16'd1;
  assign shift_last   = shift_q == ShiftW'(Height - 1);

  // The empty flag is a single-cycle pulse, one per consumed X column block
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cols_q    <= '0;
      w_iters_q <= '0;
      rows_q    <= '0;
      x_done_q  <= 1'b0;
    end else if (restart) begin
      cols_q    <= '0;
      w_iters_q <= '0;
      rows_q    <= '0;
      x_done_q  <= 1'b0;
    end else if (x_empty_i && !x_done_q) begin
      cols_q <= cols_last ? '0 : cols_q + 16'd1;
      if (cols_last) begin
        w_iters_q <= w_iters_last ? '0 : w_iters_q + 16'd1;
        if (w_iters_last) begin
          rows_q <= rows_q + 16'd1;
          if (rows_last) begin
            x_done_q <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q <= '0;
    end else if (restart) begin
      shift_q <= '0;
    end else if (w_step_i) begin
      shift_q <= shift_last ? '0 : shift_q + ShiftW'(1);
    end
  end

  // Reload is requested at start and after each empty pulse, and drops once full
  assign reload_en  = start_i || x_empty_i;
  assign reload_rst = x_full_i && !reload_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reload_q <= 1'b0;
    end else if (clear_i || reload_rst) begin
      reload_q <= 1'b0;
    end else if (reload_en) begin
      reload_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      refill_q <= 1'b0;
    end else if (restart || rst_w_index) begin
      refill_q <= 1'b0;
    end else if (x_empty_i) begin
      refill_q <= 1'b1;
    end
  end

  assign rst_w_index = w_step_i && shift_last && x_full_i;
  assign x_height    = (cols_last && cfg_i.x_height_lo != 8'd0) ? cfg_i.x_height_lo
                                                                 : 8'(TotDepth);

  assign x_ctrl_o.load        = reload_q && !reload_rst;
  assign x_ctrl_o.h_shift     = w_step_i;
  assign x_ctrl_o.pad_setup   = preload_done_i;
  assign x_ctrl_o.rst_w_index = rst_w_index;
  assign x_ctrl_o.height      = x_height;
  assign x_ctrl_o.slots       = x_height;
  assign x_ctrl_o.width       = (rows_last && cfg_i.x_width_lo != 8'd0) ? cfg_i.x_width_lo
                                                                        : 8'(Width);

  // A full X buffer is needed when the last row of the current block shifts out
  assign x_need_full_o = refill_q && shift_last;
  assign x_done_o      = x_done_q;

endmodule

`default_nettype wire

// File: w_tile_iter.sv
// W row, column and matrix iteration counters, done flag and W buffer control
`default_nettype none

module w_tile_iter #(
  parameter int unsigned Height      = sched_pkg::ArrayHeight,
  parameter int unsigned TotDepth    = sched_pkg::TotDepth,
  parameter int unsigned NumPipeRegs = sched_pkg::PipeRegs
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  sched_pkg::sched_cfg_t  cfg_i,
  input  logic                   clear_i,
  input  logic                   w_step_i,
  input  logic                   wait_step_i,
  output sched_pkg::w_buf_ctrl_t w_ctrl_o,
  output logic                   w_done_o
);

  logic [15:0] rows_q;
  logic [15:0] cols_q;
  logic [15:0] mat_q;
  logic        w_done_q;
  logic        rows_last;
  logic        cols_last;
  logic        mat_last;
  logic        rows_near_end;

  assign rows_last = rows_q == cfg_i.w_rows_iters - 16'd1;
  assign cols_last = cols_q == cfg_i.w_cols_iters - 16'd1;
  assign mat_last  = mat_q == cfg_i.x_rows_iters - 16'd1;

  // Rows wrap into columns and columns into matrix passes, one pass per X row block
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_q   <= '0;
      cols_q   <= '0;
      mat_q    <= '0;
      w_done_q <= 1'b0;
    end else if (clear_i) begin
      rows_q   <= '0;
      cols_q   <= '0;
      mat_q    <= '0;
      w_done_q <= 1'b0;
    end else if (w_step_i && !w_done_q) begin
      rows_q <= rows_last ? '0 : rows_q + 16'd1;
      if (rows_last) begin
        cols_q <= cols_last ? '0 : cols_q + 16'd1;
        if (cols_last) begin
          mat_q <= mat_q + 16'd1;
          if (mat_last) begin
            w_done_q <= 1'b1;
          end
        end
      end
    end
  end

  // The leftover height already applies while the pipeline still drains,
  // so the compare is widened to avoid wrap on short jobs
  assign rows_near_end = ({1'b0, rows_q} + 17'(NumPipeRegs + 1)) >= {1'b0, cfg_i.w_rows_iters};

  assign w_ctrl_o.load   = w_step_i;
  assign w_ctrl_o.shift  = w_step_i || wait_step_i;
  assign w_ctrl_o.height = (rows_near_end && cfg_i.w_height_lo != 8'd0) ? cfg_i.w_height_lo
                                                                        : 8'(Height);
  assign w_ctrl_o.width  = (cols_last && cfg_i.w_width_lo != 8'd0) ? cfg_i.w_width_lo
                                                                   : 8'(TotDepth);

  assign w_done_o = w_done_q;

endmodule

`default_nettype wire

// File: sched_fsm.sv
// Scheduler FSM with stall checks, pipeline wait counter and compute flag
`default_nettype none

module sched_fsm #(
  parameter int unsigned NumPipeRegs = sched_pkg::PipeRegs
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic clear_i,
  input  logic x_full_i,
  input  logic w_valid_i,
  input  logic x_need_full_i,
  input  logic w_done_i,
  output logic w_step_o,
  output logic wait_step_o,
  output logic preload_done_o,
  output logic reg_enable_o,
  output logic busy_o,
  output logic done_o
);

  localparam int unsigned WaitW = (NumPipeRegs > 0) ? $clog2(NumPipeRegs + 1) : 1;

  typedef enum logic [1:0] {
    IDLE,
    PRELOAD,
    LOAD_W,
    WAIT
  } state_e;

  state_e           state_q;
  state_e           state_d;
  logic [WaitW-1:0] wait_q;
  logic             wait_last;
  logic             stall;
  logic             preload_done;
  logic             finish;
  logic             computing_q;
  logic             done_q;

  // Stall on a missing W row, or on a pending X block that is not yet loaded
  assign stall = (state_q == LOAD_W) &&
                 ((!w_valid_i && !w_done_i) || (x_need_full_i && !x_full_i));

  assign wait_last    = wait_q == WaitW'(NumPipeRegs);
  assign preload_done = (state_q == PRELOAD) && x_full_i;
  assign finish       = (state_q == WAIT) && wait_last && w_done_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = PRELOAD;
        end
      end
      PRELOAD: begin
        if (x_full_i) begin
          state_d = LOAD_W;
        end
      end
      LOAD_W: begin
        if (!stall) begin
          state_d = WAIT;
        end
      end
      // Let the pipeline advance before the next W row goes in
      WAIT: begin
        if (wait_last) begin
          state_d = w_done_i ? IDLE : LOAD_W;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q <= '0;
    end else if (clear_i) begin
      wait_q <= '0;
    end else if (state_q == WAIT) begin
      wait_q <= wait_last ? '0 : wait_q + WaitW'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      computing_q <= 1'b0;
    end else if (clear_i || finish) begin
      computing_q <= 1'b0;
    end else if (preload_done) begin
      computing_q <= 1'b1;
    end
  end

  // Done stays up after the job until the host starts another one or clears
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (clear_i || start_i) begin
      done_q <= 1'b0;
    end else if (finish) begin
      done_q <= 1'b1;
    end
  end

  assign w_step_o       = (state_q == LOAD_W) && !stall;
  assign wait_step_o    = state_q == WAIT;
  assign preload_done_o = preload_done;
  assign reg_enable_o   = computing_q && !stall;
  assign busy_o         = state_q != IDLE;
  assign done_o         = done_q;

endmodule

`default_nettype wire

// File: redmule_sched_top.sv
// Tile scheduler top level with configuration registers, X and W
// iteration counters and the control FSM
`default_nettype none

module redmule_sched_top #(
  parameter int unsigned Height      = sched_pkg::ArrayHeight,
  parameter int unsigned Width       = sched_pkg::ArrayWidth,
  parameter int unsigned TotDepth    = sched_pkg::TotDepth,
  parameter int unsigned NumPipeRegs = sched_pkg::PipeRegs
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  sched_pkg::wb_req_t     wb_req_i,
  input  logic                   x_full_i,
  input  logic                   x_empty_i,
  input  logic                   w_valid_i,
  output sched_pkg::wb_rsp_t     wb_rsp_o,
  output sched_pkg::x_buf_ctrl_t x_ctrl_o,
  output sched_pkg::w_buf_ctrl_t w_ctrl_o,
  output logic                   reg_enable_o,
  output logic                   busy_o,
  output logic                   done_o
);

  sched_pkg::sched_cfg_t cfg;
  logic                  start;
  logic                  clear;
  logic                  w_step;
  logic                  wait_step;
  logic                  preload_done;
  logic                  x_need_full;
  logic                  x_done;
  logic                  w_done;

  sched_cfg_regs i_cfg_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .cfg_o    (cfg),
    .start_o  (start),
    .clear_o  (clear)
  );

  x_tile_iter #(
    .Height   (Height),
    .TotDepth (TotDepth),
    .Width    (Width)
  ) i_x_tile_iter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cfg_i          (cfg),
    .start_i        (start),
    .clear_i        (clear),
    .x_full_i       (x_full_i),
    .x_empty_i      (x_empty_i),
    .w_step_i       (w_step),
    .preload_done_i (preload_done),
    .x_ctrl_o       (x_ctrl_o),
    .x_need_full_o  (x_need_full),
    .x_done_o       (x_done)
  );

  // W counters restart with every new job as well as on clear
  w_tile_iter #(
    .Height      (Height),
    .TotDepth    (TotDepth),
    .NumPipeRegs (NumPipeRegs)
  ) i_w_tile_iter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg),
    .clear_i     (clear || start),
    .w_step_i    (w_step),
    .wait_step_i (wait_step),
    .w_ctrl_o    (w_ctrl_o),
    .w_done_o    (w_done)
  );

  // Once all X blocks are consumed no further refill is awaited
  sched_fsm #(
    .NumPipeRegs (NumPipeRegs)
  ) i_sched_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start),
    .clear_i        (clear),
    .x_full_i       (x_full_i),
    .w_valid_i      (w_valid_i),
    .x_need_full_i  (x_need_full && !x_done),
    .w_done_i       (w_done),
    .w_step_o       (w_step),
    .wait_step_o    (wait_step),
    .preload_done_o (preload_done),
    .reg_enable_o   (reg_enable_o),
    .busy_o         (busy_o),
    .done_o         (done_o)
  );

endmodule

`default_nettype wire

// File: tb_sched.sv
// Testbench for the tile scheduler with Wishbone access tasks, an X buffer
// model, table-driven jobs and a watchdog
`default_nettype none

module tb_sched;

  localparam int unsigned MaxTests  = 16;
  localparam int unsigned ClkPeriod = 8;
  localparam int unsigned JobSetup  = 64;

  logic                   clk_i;
  logic                   rst_ni;
  sched_pkg::wb_req_t     wb_req;
  sched_pkg::wb_rsp_t     wb_rsp;
  logic                   x_full;
  logic                   x_empty;
  logic                   w_valid;
  sched_pkg::x_buf_ctrl_t x_ctrl;
  sched_pkg::w_buf_ctrl_t w_ctrl;
  logic                   reg_enable;
  logic                   busy;
  logic                   done;

  logic [127:0] test_name [MaxTests];
  logic [31:0]  test_x_iters [MaxTests];
  logic [31:0]  test_w_iters [MaxTests];
  logic [31:0]  test_leftovers [MaxTests];
  int unsigned  test_gap [MaxTests];
  int unsigned  test_abort [MaxTests];
  int unsigned  test_loads [MaxTests];
  int unsigned  num_tests;
  int unsigned  watchdog_cycles;
  string        cur_test;
  logic [31:0]  rng_state;
  logic         x_loaded;

  redmule_sched_top DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_req_i     (wb_req),
    .x_full_i     (x_full),
    .x_empty_i    (x_empty),
    .w_valid_i    (w_valid),
    .wb_rsp_o     (wb_rsp),
    .x_ctrl_o     (x_ctrl),
    .w_ctrl_o     (w_ctrl),
    .reg_enable_o (reg_enable),
    .busy_o       (busy),
    .done_o       (done)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string label, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                         cur_test, label, expected, actual));
    end
  endtask

  // One classic cycle drives the request on a falling edge, holds it until ack and drops stb
  task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int unsigned waited;
    @(negedge clk_i);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdata;
    waited = 0;
    @(negedge clk_i);
    while (!wb_rsp.ack) begin
      waited++;
      if (waited > 16) begin
        fail_run("The Wishbone slave did not acknowledge an access");
      end
      @(negedge clk_i);
    end
    rdata      = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    @(negedge clk_i);
    check_value("ack lasts one cycle", 32'd0, 32'(wb_rsp.ack));
  endtask

  task automatic reg_write(input sched_pkg::sched_reg_e adr, input logic [31:0] data);
    logic [31:0] ignored;
    bus_access(1'b1, adr, data, ignored);
  endtask

  task automatic reg_read_check(input string label, input sched_pkg::sched_reg_e adr,
                                input logic [31:0] expected);
    logic [31:0] rdata;
    bus_access(1'b0, adr, 32'd0, rdata);
    check_value(label, expected, rdata);
  endtask

  task automatic load_tests();
    int           fd;
    int           count;
    string        line;
    logic [127:0] name;
    logic [31:0]  xw;
    logic [31:0]  ww;
    logic [31:0]  lw;
    int unsigned  gap;
    int unsigned  abort_at;
    int unsigned  loads;
    fd = $fopen("sched_testdata.txt", "r");
    if (fd == 0) begin
      fail_run("Could not open the stimulus file sched_testdata.txt");
    end
    num_tests = 0;
    while (!$feof(fd) && num_tests < MaxTests) begin
      line  = "";
      count = $fgets(line, fd);
      if (count > 0 && line.getc(0) != "#") begin
        count = $sscanf(line, "%s %h %h %h %d %d %d", name, xw, ww, lw, gap, abort_at, loads);
        if (count == 7) begin
          test_name[num_tests]      = name;
          test_x_iters[num_tests]   = xw;
          test_w_iters[num_tests]   = ww;
          test_leftovers[num_tests] = lw;
          test_gap[num_tests]       = gap;
          test_abort[num_tests]     = abort_at;
          test_loads[num_tests]     = loads;
          num_tests++;
        end
      end
    end
    $fclose(fd);
  endtask

  // Clear in the middle of a job must drop busy and done right away
  task automatic clear_job();
    @(negedge clk_i);
    x_empty = 1'b0;
    w_valid = 1'b1;
    reg_write(sched_pkg::REG_CTRL, 32'h2);
    @(negedge clk_i);
    #1;
    check_value("busy after clear", 32'd0, 32'(busy));
    check_value("done after clear", 32'd0, 32'(done));
  endtask

  task automatic run_job(input int unsigned t);
    int unsigned loads;
    int unsigned w_row;
    int unsigned w_col;
    int unsigned wait_left;
    logic [15:0] x_cols;
    logic [15:0] x_rows;
    logic [15:0] w_cols;
    logic [15:0] w_rows;
    logic [7:0]  x_height_lo;
    logic [7:0]  x_width_lo;
    logic [7:0]  w_height_lo;
    logic [7:0]  w_width_lo;
    logic [7:0]  exp_height;
    logic [7:0]  exp_width;
    logic [15:0] xm_cols;
    logic [15:0] xm_w_iters;
    logic [15:0] xm_rows;
    logic        xm_done;
    logic        finished;
    x_cols      = test_x_iters[t][15:0];
    x_rows      = test_x_iters[t][31:16];
    w_cols      = test_w_iters[t][15:0];
    w_rows      = test_w_iters[t][31:16];
    x_width_lo  = test_leftovers[t][31:24];
    x_height_lo = test_leftovers[t][23:16];
    w_height_lo = test_leftovers[t][15:8];
    w_width_lo  = test_leftovers[t][7:0];
    reg_write(sched_pkg::REG_X_ITERS, test_x_iters[t]);
    reg_write(sched_pkg::REG_W_ITERS, test_w_iters[t]);
    reg_write(sched_pkg::REG_LEFTOVERS, test_leftovers[t]);
    reg_read_check("x iters read-back", sched_pkg::REG_X_ITERS, test_x_iters[t]);
    reg_read_check("w iters read-back", sched_pkg::REG_W_ITERS, test_w_iters[t]);
    reg_read_check("leftovers read-back", sched_pkg::REG_LEFTOVERS, test_leftovers[t]);
    reg_read_check("ctrl reads zero", sched_pkg::REG_CTRL, 32'd0);
    xm_cols    = 16'd0;
    xm_w_iters = 16'd0;
    xm_rows    = 16'd0;
    xm_done    = 1'b0;
    loads      = 0;
    wait_left  = 0;
    finished   = 1'b0;
    reg_write(sched_pkg::REG_CTRL, 32'h1);
    while (!finished) begin
      @(negedge clk_i);
      rng_state = next_random(rng_state);
      w_valid   = (rng_state % 100) >= test_gap[t];
      rng_state = next_random(rng_state);
      x_empty   = (rng_state % 6) == 0;
      x_full    = x_loaded;
      #1;
      if (done) begin
        check_value("busy low at done", 32'd0, 32'(busy));
        check_value("pipeline wait before done", 32'd0, wait_left);
        check_value("w load count", test_loads[t], loads);
        finished = 1'b1;
      end else begin
        exp_height = (xm_cols == x_cols - 16'd1 && x_height_lo != 8'd0) ? x_height_lo
                                                                       : 8'(sched_pkg::TotDepth);
        check_value("x tile height", 32'(exp_height), 32'(x_ctrl.height));
        check_value("x tile slots", 32'(exp_height), 32'(x_ctrl.slots));
        exp_width = (xm_rows == x_rows - 16'd1 && x_width_lo != 8'd0) ? x_width_lo
                                                                     : 8'(sched_pkg::ArrayWidth);
        check_value("x tile width", 32'(exp_width), 32'(x_ctrl.width));
        // W row and column follow from the number of loads issued so far
        w_row      = loads % w_rows;
        w_col      = (loads / w_rows) % w_cols;
        exp_height = (w_row + sched_pkg::PipeRegs + 1 >= w_rows && w_height_lo != 8'd0)
                     ? w_height_lo : 8'(sched_pkg::ArrayHeight);
        check_value("w tile height", 32'(exp_height), 32'(w_ctrl.height));
        exp_width  = (w_col == w_cols - 1 && w_width_lo != 8'd0) ? w_width_lo
                                                                 : 8'(sched_pkg::TotDepth);
        check_value("w tile width", 32'(exp_width), 32'(w_ctrl.width));
        // Each W load is followed by PipeRegs+1 wait cycles that keep shifting
        if (wait_left != 0) begin
          check_value("w load during wait", 32'd0, 32'(w_ctrl.load));
          check_value("w shift during wait", 32'd1, 32'(w_ctrl.shift));
          check_value("enable during wait", 32'd1, 32'(reg_enable));
          wait_left--;
        end else if (!w_valid) begin
          check_value("w load while w_valid low", 32'd0, 32'(w_ctrl.load));
          check_value("w shift while stalled", 32'd0, 32'(w_ctrl.shift));
          check_value("enable while stalled", 32'd0, 32'(reg_enable));
        end
        if (w_ctrl.load) begin
          check_value("w shift with load", 32'd1, 32'(w_ctrl.shift));
          loads++;
          wait_left = sched_pkg::PipeRegs + 1;
        end
        // An empty pulse drains the X buffer until the next load refills it
        if (x_empty) begin
          x_loaded = 1'b0;
        end
        if (x_ctrl.load) begin
          x_loaded = 1'b1;
        end
        if (x_empty && !xm_done) begin
          if (xm_cols == x_cols - 16'd1) begin
            xm_cols = 16'd0;
            if (xm_w_iters == w_cols - 16'd1) begin
              xm_w_iters = 16'd0;
              xm_rows    = xm_rows + 16'd1;
              xm_done    = xm_rows == x_rows;
            end else begin
              xm_w_iters = xm_w_iters + 16'd1;
            end
          end else begin
            xm_cols = xm_cols + 16'd1;
          end
        end
        if (test_abort[t] != 0 && loads == test_abort[t]) begin
          clear_job();
          finished = 1'b1;
        end
      end
    end
    @(negedge clk_i);
    x_empty = 1'b0;
    w_valid = 1'b0;
  endtask

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk_i);
    fail_run("The watchdog expired before all jobs reached done");
  end

  initial begin
    int unsigned total_loads;
    rst_ni          = 1'b0;
    wb_req          = '0;
    x_full          = 1'b0;
    x_empty         = 1'b0;
    w_valid         = 1'b0;
    x_loaded        = 1'b0;
    rng_state       = 32'ha1aa;
    cur_test        = "reset";
    watchdog_cycles = 0;
    load_tests();
    if (num_tests == 0) begin
      fail_run("No test was found in sched_testdata.txt");
    end
    total_loads = 0;
    for (int unsigned t = 0; t < num_tests; t++) begin
      total_loads += test_loads[t];
    end
    watchdog_cycles = total_loads * 4 * (sched_pkg::PipeRegs + 2) * 2 + JobSetup * num_tests;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("strobes after reset", 32'd0,
                {22'd0, x_ctrl.load, x_ctrl.h_shift, x_ctrl.pad_setup, x_ctrl.rst_w_index,
                 w_ctrl.load, w_ctrl.shift, reg_enable, busy, done, wb_rsp.ack});
    for (int unsigned t = 0; t < num_tests; t++) begin
      cur_test = $sformatf("%0s", test_name[t]);
      run_job(t);
    end
    // Done is sticky after the last job and only a clear drops it
    cur_test = "clear after done";
    check_value("done held after job", 32'd1, 32'(done));
    clear_job();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sched_testdata.txt
# name  x_iters(rows,cols)  w_iters(rows,cols)  leftovers(xw,xh,wh,ww)  gap%  clear_at  loads
# The three words are hex and the rest decimal; clear_at 0 lets the job run to done
basic          00010002 00020003 00000000  0 0   6
x_leftover     00020003 00040002 06050302  0 0  16
stall_light    00020002 00030003 00040000 25 0  18
stall_heavy    00030004 00050002 07030405 50 0  30
single_tile    00010001 00010001 00000000  0 0   1
clear_mid_job  00040004 00080004 00000000 10 5 128
after_clear    00020003 00030002 00020000 20 0  12
large_job      00040003 00060004 01020304 30 0  96
one_x_column   00030001 00020002 00030000 15 0  12

// File: src.f
sched_pkg.sv
sched_cfg_regs.sv
x_tile_iter.sv
w_tile_iter.sv
sched_fsm.sv
redmule_sched_top.sv
tb_sched.sv

// File: run.sh
#!/usr/bin/env bash
# Build the scheduler testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_sched -f src.f -o tb_sched \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sched > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
